// File: sources.f
rtl/fp_format_pkg.sv
rtl/mul_pipe_pkg.sv
rtl/lzc24.sv
rtl/fmul_prenorm.sv
rtl/fmul_exp_align.sv
rtl/fmul_partial_products.sv
rtl/fmul_product_sum.sv
rtl/fmul_core.sv
tests/fmul_assertions.sv
tests/fmul_tb.sv

// File: tests/fmul_tb.sv
////////////////////////////////////////////////////////////
// testbench for fmul_core: random operand sets from an LFSR,
// checked at each falling edge against a pipeline model
////////////////////////////////////////////////////////////

module fmul_tb;

  localparam int BIAS  = fp_format_pkg::EXP_BIAS;
  localparam int N_OPS = 2000;
  // 40 cycles per operation plus the reset time, 20 units each
  localparam int WATCHDOG_T = (N_OPS * 40 + 10) * 20;

  // expected output set of one operation
  typedef struct packed {
    logic        valid;
    logic        sign;
    logic [4:0]  shr;
    logic [9:0]  exprx;
    logic [9:0]  expc;
    logic [27:0] fract;
    logic        inv;
    logic        inf;
    logic        snan;
    logic        qnan;
    logic        anan_sign;
  } result_t;

  logic clk = 1'b0;
  logic rst;
  logic flush_i, adv_i, start_i;
  logic signa_i, infa_i, zeroa_i;
  logic signb_i, infb_i, zerob_i;
  logic snan_i, qnan_i, anan_sign_i;
  fp_format_pkg::exp_t   exp10a_i, exp10b_i;
  fp_format_pkg::fract_t fract24a_i, fract24b_i;
  logic rdy_o, sign_o, inv_o, inf_o, snan_o, qnan_o, anan_sign_o;
  mul_pipe_pkg::shr_t    shr_o;
  fp_format_pkg::exp_t   exp10shr_o, exp10sh0_o;
  logic [mul_pipe_pkg::FRACT28_W-1:0] fract28_o;

  // model state, slot 3 mirrors the output registers
  result_t     pipe [4];
  logic        adv_seen;
  logic [58:0] out_now, out_prev;
  logic [31:0] lfsr = 32'h6178_1a43;
  int          errors = 0;
  int          checked = 0;
  int          issued = 0;

  fmul_core #(.EXP_BIAS(BIAS)) dut (.*);

  always #10 clk = ~clk;

  // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // mostly the single-precision range, sometimes the full 10 bits
  function automatic fp_format_pkg::exp_t rand_exp();
    if (rand_bits(3) == 0) return 10'(rand_bits(10));
    return 10'(rand_bits(8));
  endfunction

  function automatic fp_format_pkg::fract_t rand_fract();
    logic [1:0]            mode;
    logic [2:0]            sh;
    fp_format_pkg::fract_t f;
    mode = 2'(rand_bits(2));
    if (!mode[1]) begin
      // normal, hidden bit set
      f = {1'b1, 23'(rand_bits(23))};
    end else if (mode == 2'd2) begin
      // a few leading zeros
      f  = 24'(rand_bits(24));
      sh = 3'(rand_bits(3));
      f  = f >> sh;
    end else if (rand_bits(1) == 1) begin
      f = '0;
    end else begin
      f = 24'(rand_bits(24));
    end
    return f;
  endfunction

  // position of the first one from the top, 0 for no one at all
  function automatic logic [4:0] lead_zeros(input fp_format_pkg::fract_t f);
    logic [4:0] n;
    logic       found;
    n     = '0;
    found = 1'b0;
    for (int i = 23; i >= 0; i--) begin
      if (f[i] && !found) begin
        n     = 5'(23 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  // expected outputs for the operand set now on the inputs
  function automatic result_t predict();
    result_t               r;
    logic [4:0]            nlza, nlzb;
    fp_format_pkg::fract_t na, nb;
    logic [47:0]           prod;
    fp_format_pkg::exp_t   sum;
    logic [9:0]            shr_full;
    logic                  zf;
    zf   = zeroa_i | zerob_i;
    nlza = lead_zeros(fract24a_i);
    nlzb = lead_zeros(fract24b_i);
    na   = zf ? '0 : fract24a_i << nlza;
    nb   = zf ? '0 : fract24b_i << nlzb;
    prod = 48'(na) * 48'(nb);
    sum  = zf ? '0 : exp10a_i - 10'(nlza) + exp10b_i - 10'(nlzb) - 10'(BIAS);
    if (zf) begin
      shr_full = '0;
      r.exprx  = '0;
    end else if (sum[9]) begin
      // negative sum, denormal range
      shr_full = 10'(11'd1025 - {1'b0, sum});
      r.exprx  = 10'd1;
    end else begin
      shr_full = (sum == 0) ? 10'd1 : 10'd0;
      r.exprx  = (sum == 0) ? 10'd1 : sum;
    end
    r.valid     = 1'b0;
    r.sign      = signa_i ^ signb_i;
    r.shr       = (shr_full > 10'd31) ? 5'd31 : shr_full[4:0];
    r.expc      = sum;
    r.fract     = {prod[47:21], |prod[20:0]};
    r.inv       = (zeroa_i & infb_i) | (zerob_i & infa_i);
    r.inf       = infa_i | infb_i;
    r.snan      = snan_i;
    r.qnan      = qnan_i;
    r.anan_sign = anan_sign_i;
    return r;
  endfunction

  task automatic drive_idle();
    start_i <= 1'b0;
    adv_i   <= 1'b1;
    flush_i <= 1'b0;
  endtask

  task automatic drive_random();
    start_i     <= (rand_bits(5) < 26);
    adv_i       <= (rand_bits(2) != 0);
    flush_i     <= (rand_bits(6) == 0);
    signa_i     <= 1'(rand_bits(1));
    exp10a_i    <= rand_exp();
    fract24a_i  <= rand_fract();
    infa_i      <= (rand_bits(4) == 0);
    zeroa_i     <= (rand_bits(4) == 0);
    signb_i     <= 1'(rand_bits(1));
    exp10b_i    <= rand_exp();
    fract24b_i  <= rand_fract();
    infb_i      <= (rand_bits(4) == 0);
    zerob_i     <= (rand_bits(4) == 0);
    snan_i      <= (rand_bits(3) == 0);
    qnan_i      <= (rand_bits(3) == 0);
    anan_sign_i <= 1'(rand_bits(1));
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("ERROR %s: expected %0h, actual %0h at %0t", name, exp_v, act_v, $time);
  endtask

  ////////////////////////////////////////////////////////////
  // model update and stimulus, rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    // inputs read here are the ones the DUT samples on this edge
    adv_seen = adv_i;
    if (adv_i) begin
      pipe[3]       = pipe[2];
      pipe[2]       = pipe[1];
      pipe[1]       = pipe[0];
      pipe[0]       = predict();
      pipe[0].valid = start_i;
      if (start_i && !rst) issued++;
    end
    if (rst || flush_i) begin
      for (int k = 0; k < 4; k++) pipe[k].valid = 1'b0;
    end
    if (rst || issued >= N_OPS) drive_idle();
    else drive_random();
  end

  ////////////////////////////////////////////////////////////
  // checks, falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    out_now = {sign_o, shr_o, exp10shr_o, exp10sh0_o, fract28_o,
               inv_o, inf_o, snan_o, qnan_o, anan_sign_o};
    if (rdy_o !== pipe[3].valid) report_mismatch("ready", 32'(pipe[3].valid), 32'(rdy_o));
    if (pipe[3].valid === 1'b1) begin
      checked++;
      if (fract28_o !== pipe[3].fract)
        report_mismatch("fraction", 32'(pipe[3].fract), 32'(fract28_o));
      if (sign_o !== pipe[3].sign) report_mismatch("sign", 32'(pipe[3].sign), 32'(sign_o));
      if (exp10sh0_o !== pipe[3].expc)
        report_mismatch("exponent sum", 32'(pipe[3].expc), 32'(exp10sh0_o));
      if (shr_o !== pipe[3].shr) report_mismatch("right shift", 32'(pipe[3].shr), 32'(shr_o));
      if (exp10shr_o !== pipe[3].exprx)
        report_mismatch("shift exponent", 32'(pipe[3].exprx), 32'(exp10shr_o));
      if (inv_o !== pipe[3].inv) report_mismatch("invalid", 32'(pipe[3].inv), 32'(inv_o));
      if (inf_o !== pipe[3].inf) report_mismatch("infinity", 32'(pipe[3].inf), 32'(inf_o));
      if (snan_o !== pipe[3].snan) report_mismatch("snan", 32'(pipe[3].snan), 32'(snan_o));
      if (qnan_o !== pipe[3].qnan) report_mismatch("qnan", 32'(pipe[3].qnan), 32'(qnan_o));
      if (anan_sign_o !== pipe[3].anan_sign)
        report_mismatch("nan sign", 32'(pipe[3].anan_sign), 32'(anan_sign_o));
    end
    // no advance means every output register holds
    if (!adv_seen && out_now !== out_prev) begin
      errors++;
      $display("outputs changed on an edge where adv_i was low, at %0t", $time);
    end
    out_prev = out_now;
  end

  initial begin
    rst         = 1'b1;
    flush_i     = 1'b0;
    adv_i       = 1'b1;
    start_i     = 1'b0;
    signa_i     = 1'b0;
    exp10a_i    = '0;
    fract24a_i  = '0;
    infa_i      = 1'b0;
    zeroa_i     = 1'b0;
    signb_i     = 1'b0;
    exp10b_i    = '0;
    fract24b_i  = '0;
    infb_i      = 1'b0;
    zerob_i     = 1'b0;
    snan_i      = 1'b0;
    qnan_i      = 1'b0;
    anan_sign_i = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    wait (issued >= N_OPS);
    // let the last operations drain through the pipeline
    repeat (8) @(posedge clk);
    if (checked == 0) begin
      errors++;
      $display("no result ever reached the outputs");
    end
    $display("errors: %0d, results checked: %0d, operations started: %0d",
             errors, checked, issued);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_T);
    $display("watchdog expired before all operations were done");
    $display("tests failed");
    $finish;
  end

endmodule

// File: tests/fmul_assertions.sv
////////////////////////////////////////////////////////////
// concurrent checks on flush, hold and rdy_o, bound below
// into every fmul_core instance
////////////////////////////////////////////////////////////

module fmul_assertions (
  input logic clk,
  input logic rst,
  input logic flush_i,
  input logic adv_i,
  input logic rdy_i,
  // all data outputs side by side
  input logic [mul_pipe_pkg::SHR_W + 2*fp_format_pkg::EXP_W + mul_pipe_pkg::FRACT28_W + 5:0] outs_i
);

  // flush empties the valid chain on the next edge
  flush_clears_rdy: assert property (@(posedge clk) disable iff (rst) flush_i |=> !rdy_i)
    else $error("rdy_o high on the edge after flush_i");

  // no advance, no change
  outputs_hold: assert property (@(posedge clk) disable iff (rst) !adv_i |=> $stable(outs_i))
    else $error("outputs changed on an edge without adv_i");

  rdy_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(rdy_i))
    else $error("rdy_o unknown after reset");

endmodule

bind fmul_core fmul_assertions u_assertions (
  .clk     (clk),
  .rst     (rst),
  .flush_i (flush_i),
  .adv_i   (adv_i),
  .rdy_i   (rdy_o),
  .outs_i  ({sign_o, shr_o, exp10shr_o, exp10sh0_o, fract28_o,
             inv_o, inf_o, snan_o, qnan_o, anan_sign_o})
);

// File: rtl/fmul_core.sv
////////////////////////////////////////////////////////////
// floating-point multiply core, four advancing edges from
// start_i to rdy_o; feeds the align and rounding stage
////////////////////////////////////////////////////////////

module fmul_core #(
  parameter int EXP_BIAS = fp_format_pkg::EXP_BIAS
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               flush_i,
  input  logic                               adv_i,
  input  logic                               start_i,
  input  logic                               signa_i,
  input  fp_format_pkg::exp_t                exp10a_i,
  input  fp_format_pkg::fract_t              fract24a_i,
  input  logic                               infa_i,
  input  logic                               zeroa_i,
  input  logic                               signb_i,
  input  fp_format_pkg::exp_t                exp10b_i,
  input  fp_format_pkg::fract_t              fract24b_i,
  input  logic                               infb_i,
  input  logic                               zerob_i,
  input  logic                               snan_i,
  input  logic                               qnan_i,
  input  logic                               anan_sign_i,
  output logic                               rdy_o,
  output logic                               sign_o,
  output mul_pipe_pkg::shr_t                 shr_o,
  output fp_format_pkg::exp_t                exp10shr_o,
  output fp_format_pkg::exp_t                exp10sh0_o,
  output logic [mul_pipe_pkg::FRACT28_W-1:0] fract28_o,
  output logic                               inv_o,
  output logic                               inf_o,
  output logic                               snan_o,
  output logic                               qnan_o,
  output logic                               anan_sign_o
);

  localparam int PRW = 2 * mul_pipe_pkg::HALF_W;

  // stage 0 to stage 1
  logic                            s0_ready, s0_inv, s0_inf, s0_snan, s0_qnan;
  logic                            s0_anan_sign, s0_opc_0, s0_sign;
  fp_format_pkg::exp_t             s0_exp10a, s0_exp10b;
  fp_format_pkg::fract_t           s0_fract24a, s0_fract24b;
  logic [fp_format_pkg::NLZ_W-1:0] s0_nlza, s0_nlzb;
  // normalized fractions into the multiplier
  fp_format_pkg::fract_t           norm_a, norm_b;
  // stage 2 to stage 3
  logic                            s2_ready, s2_inv, s2_inf, s2_snan, s2_qnan;
  logic                            s2_anan_sign, s2_sign;
  fp_format_pkg::exp_t             s2_exp10c, s2_exp10rx;
  mul_pipe_pkg::shr_t              s2_shrx;
  logic [PRW-1:0]                  albl, albh, ahbl, ahbh;

  fmul_prenorm u_prenorm (
    .clk            (clk),
    .rst            (rst),
    .flush_i        (flush_i),
    .adv_i          (adv_i),
    .start_i        (start_i),
    .signa_i        (signa_i),
    .exp10a_i       (exp10a_i),
    .fract24a_i     (fract24a_i),
    .infa_i         (infa_i),
    .zeroa_i        (zeroa_i),
    .signb_i        (signb_i),
    .exp10b_i       (exp10b_i),
    .fract24b_i     (fract24b_i),
    .infb_i         (infb_i),
    .zerob_i        (zerob_i),
    .snan_i         (snan_i),
    .qnan_i         (qnan_i),
    .anan_sign_i    (anan_sign_i),
    .s0_ready_o     (s0_ready),
    .s0_inv_o       (s0_inv),
    .s0_inf_o       (s0_inf),
    .s0_snan_o      (s0_snan),
    .s0_qnan_o      (s0_qnan),
    .s0_anan_sign_o (s0_anan_sign),
    .s0_opc_0_o     (s0_opc_0),
    .s0_sign_o      (s0_sign),
    .s0_exp10a_o    (s0_exp10a),
    .s0_fract24a_o  (s0_fract24a),
    .s0_nlza_o      (s0_nlza),
    .s0_exp10b_o    (s0_exp10b),
    .s0_fract24b_o  (s0_fract24b),
    .s0_nlzb_o      (s0_nlzb)
  );

  fmul_exp_align #(
    .EXP_BIAS (EXP_BIAS)
  ) u_exp_align (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .adv_i           (adv_i),
    .s0_ready_i      (s0_ready),
    .s0_inv_i        (s0_inv),
    .s0_inf_i        (s0_inf),
    .s0_snan_i       (s0_snan),
    .s0_qnan_i       (s0_qnan),
    .s0_anan_sign_i  (s0_anan_sign),
    .s0_opc_0_i      (s0_opc_0),
    .s0_sign_i       (s0_sign),
    .s0_exp10a_i     (s0_exp10a),
    .s0_fract24a_i   (s0_fract24a),
    .s0_nlza_i       (s0_nlza),
    .s0_exp10b_i     (s0_exp10b),
    .s0_fract24b_i   (s0_fract24b),
    .s0_nlzb_i       (s0_nlzb),
    .norm_fract24a_o (norm_a),
    .norm_fract24b_o (norm_b),
    .s2_ready_o      (s2_ready),
    .s2_inv_o        (s2_inv),
    .s2_inf_o        (s2_inf),
    .s2_snan_o       (s2_snan),
    .s2_qnan_o       (s2_qnan),
    .s2_anan_sign_o  (s2_anan_sign),
    .s2_sign_o       (s2_sign),
    .s2_exp10c_o     (s2_exp10c),
    .s2_shrx_o       (s2_shrx),
    .s2_exp10rx_o    (s2_exp10rx)
  );

  fmul_partial_products u_partial_products (
    .clk             (clk),
    .adv_i           (adv_i),
    .norm_fract24a_i (norm_a),
    .norm_fract24b_i (norm_b),
    .albl_o          (albl),
    .albh_o          (albh),
    .ahbl_o          (ahbl),
    .ahbh_o          (ahbh)
  );

  fmul_product_sum u_product_sum (
    .clk            (clk),
    .rst            (rst),
    .flush_i        (flush_i),
    .adv_i          (adv_i),
    .albl_i         (albl),
    .albh_i         (albh),
    .ahbl_i         (ahbl),
    .ahbh_i         (ahbh),
    .s2_ready_i     (s2_ready),
    .s2_inv_i       (s2_inv),
    .s2_inf_i       (s2_inf),
    .s2_snan_i      (s2_snan),
    .s2_qnan_i      (s2_qnan),
    .s2_anan_sign_i (s2_anan_sign),
    .s2_sign_i      (s2_sign),
    .s2_exp10c_i    (s2_exp10c),
    .s2_shrx_i      (s2_shrx),
    .s2_exp10rx_i   (s2_exp10rx),
    .rdy_o          (rdy_o),
    .sign_o         (sign_o),
    .shr_o          (shr_o),
    .exp10shr_o     (exp10shr_o),
    .exp10sh0_o     (exp10sh0_o),
    .fract28_o      (fract28_o),
    .inv_o          (inv_o),
    .inf_o          (inf_o),
    .snan_o         (snan_o),
    .qnan_o         (qnan_o),
    .anan_sign_o    (anan_sign_o)
  );

endmodule

// File: rtl/fmul_product_sum.sv
////////////////////////////////////////////////////////////
// stage 3: partial-product summation, sticky reduction and
// the core output registers
////////////////////////////////////////////////////////////

module fmul_product_sum (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  flush_i,
  input  logic                                  adv_i,
  // products from stage 2
  input  logic [2*mul_pipe_pkg::HALF_W-1:0]     albl_i,
  input  logic [2*mul_pipe_pkg::HALF_W-1:0]     albh_i,
  input  logic [2*mul_pipe_pkg::HALF_W-1:0]     ahbl_i,
  input  logic [2*mul_pipe_pkg::HALF_W-1:0]     ahbh_i,
  // stage 2 state
  input  logic                                  s2_ready_i,
  input  logic                                  s2_inv_i,
  input  logic                                  s2_inf_i,
  input  logic                                  s2_snan_i,
  input  logic                                  s2_qnan_i,
  input  logic                                  s2_anan_sign_i,
  input  logic                                  s2_sign_i,
  input  fp_format_pkg::exp_t                   s2_exp10c_i,
  input  mul_pipe_pkg::shr_t                    s2_shrx_i,
  input  fp_format_pkg::exp_t                   s2_exp10rx_i,
  // core outputs
  output logic                                  rdy_o,
  output logic                                  sign_o,
  output mul_pipe_pkg::shr_t                    shr_o,
  output fp_format_pkg::exp_t                   exp10shr_o,
  output fp_format_pkg::exp_t                   exp10sh0_o,
  output logic [mul_pipe_pkg::FRACT28_W-1:0]    fract28_o,
  output logic                                  inv_o,
  output logic                                  inf_o,
  output logic                                  snan_o,
  output logic                                  qnan_o,
  output logic                                  anan_sign_o
);

  localparam int HW = mul_pipe_pkg::HALF_W;
  localparam int PW = mul_pipe_pkg::PRODUCT_W;
  localparam int OW = mul_pipe_pkg::FRACT28_W;

  logic [PW-1:0] prod;

  // top 48 bits of the 64-bit product
  // low half of albl is always zero due to the operand padding
  assign prod = {ahbh_i, {HW{1'b0}}}
              + {{HW{1'b0}}, ahbl_i}
              + {{HW{1'b0}}, albh_i}
              + {{(PW-HW){1'b0}}, albl_i[2*HW-1:HW]};

  always_ff @(posedge clk) begin
    if (adv_i) begin
      // 27 product bits, the rest folded into sticky
      fract28_o   <= {prod[PW-1 -: OW-1], |prod[PW-OW:0]};
      sign_o      <= s2_sign_i;
      shr_o       <= s2_shrx_i;
      exp10shr_o  <= s2_exp10rx_i;
      exp10sh0_o  <= s2_exp10c_i;
      inv_o       <= s2_inv_i;
      inf_o       <= s2_inf_i;
      snan_o      <= s2_snan_i;
      qnan_o      <= s2_qnan_i;
      anan_sign_o <= s2_anan_sign_i;
    end
  end

  // last link of the valid chain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= s2_ready_i;
    end
  end

endmodule

// File: rtl/fmul_partial_products.sv
////////////////////////////////////////////////////////////
// split multiplier front end: operand halves in stage 1,
// four registered 16x16 products in stage 2
////////////////////////////////////////////////////////////

module fmul_partial_products (
  input  logic                                clk,
  input  logic                                adv_i,
  input  fp_format_pkg::fract_t               norm_fract24a_i,
  input  fp_format_pkg::fract_t               norm_fract24b_i,
  output logic [2*mul_pipe_pkg::HALF_W-1:0]   albl_o,
  output logic [2*mul_pipe_pkg::HALF_W-1:0]   albh_o,
  output logic [2*mul_pipe_pkg::HALF_W-1:0]   ahbl_o,
  output logic [2*mul_pipe_pkg::HALF_W-1:0]   ahbh_o
);

  localparam int HW = mul_pipe_pkg::HALF_W;
  localparam int MW = mul_pipe_pkg::MOP_W;
  localparam int PW = MW - fp_format_pkg::FRACT_W;

  // fraction padded with zeros to the operand width
  logic [MW-1:0]       mop_a;
  logic [MW-1:0]       mop_b;
  mul_pipe_pkg::half_t al, ah, bl, bh;

  assign mop_a = {norm_fract24a_i, {PW{1'b0}}};
  assign mop_b = {norm_fract24b_i, {PW{1'b0}}};

  // stage 1 operand halves
  always_ff @(posedge clk) begin
    if (adv_i) begin
      al <= mop_a[HW-1:0];
      ah <= mop_a[MW-1:HW];
      bl <= mop_b[HW-1:0];
      bh <= mop_b[MW-1:HW];
    end
  end

  // stage 2 products, full 32-bit results
  always_ff @(posedge clk) begin
    if (adv_i) begin
      albl_o <= al * bl;
      albh_o <= al * bh;
      ahbl_o <= ah * bl;
      ahbh_o <= ah * bh;
    end
  end

endmodule

// File: rtl/fmul_exp_align.sv
////////////////////////////////////////////////////////////
// stages 1 and 2: normalizing shift, exponent sum with zero
// forcing, then right-shift and exponent selection
////////////////////////////////////////////////////////////

module fmul_exp_align #(
  parameter int EXP_BIAS = fp_format_pkg::EXP_BIAS
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush_i,
  input  logic                            adv_i,
  // from stage 0
  input  logic                            s0_ready_i,
  input  logic                            s0_inv_i,
  input  logic                            s0_inf_i,
  input  logic                            s0_snan_i,
  input  logic                            s0_qnan_i,
  input  logic                            s0_anan_sign_i,
  input  logic                            s0_opc_0_i,
  input  logic                            s0_sign_i,
  input  fp_format_pkg::exp_t             s0_exp10a_i,
  input  fp_format_pkg::fract_t           s0_fract24a_i,
  input  logic [fp_format_pkg::NLZ_W-1:0] s0_nlza_i,
  input  fp_format_pkg::exp_t             s0_exp10b_i,
  input  fp_format_pkg::fract_t           s0_fract24b_i,
  input  logic [fp_format_pkg::NLZ_W-1:0] s0_nlzb_i,
  // combinational, to the multiplier
  output fp_format_pkg::fract_t           norm_fract24a_o,
  output fp_format_pkg::fract_t           norm_fract24b_o,
  // stage 2 registers
  output logic                            s2_ready_o,
  output logic                            s2_inv_o,
  output logic                            s2_inf_o,
  output logic                            s2_snan_o,
  output logic                            s2_qnan_o,
  output logic                            s2_anan_sign_o,
  output logic                            s2_sign_o,
  output fp_format_pkg::exp_t             s2_exp10c_o,
  output mul_pipe_pkg::shr_t              s2_shrx_o,
  output fp_format_pkg::exp_t             s2_exp10rx_o
);

  localparam int EW = fp_format_pkg::EXP_W;
  localparam int SW = mul_pipe_pkg::SHR_W;
  localparam int ZW = EW - fp_format_pkg::NLZ_W;

  fp_format_pkg::exp_t exp_sum;
  // stage 1 state
  logic                s1_ready;
  logic                s1_inv, s1_inf, s1_snan, s1_qnan, s1_anan_sign;
  logic                s1_opc_0;
  logic                s1_sign;
  fp_format_pkg::exp_t s1_exp10c;
  // stage 2 selection
  logic [EW:0]         shr_neg;
  fp_format_pkg::exp_t shr_full;
  fp_format_pkg::exp_t exp_rx;
  logic                exp_zero;

  ////////////////////////////////////////////////////////////
  // stage 1
  ////////////////////////////////////////////////////////////

  // normalize each fraction by its own count, zero forced
  assign norm_fract24a_o = s0_opc_0_i ? '0 : (s0_fract24a_i << s0_nlza_i);
  assign norm_fract24b_o = s0_opc_0_i ? '0 : (s0_fract24b_i << s0_nlzb_i);

  // (ea - nlza) + (eb - nlzb) - bias, wraps modulo 1024
  assign exp_sum = s0_exp10a_i - {{ZW{1'b0}}, s0_nlza_i}
                 + s0_exp10b_i - {{ZW{1'b0}}, s0_nlzb_i}
                 - EW'(EXP_BIAS);

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_inv       <= s0_inv_i;
      s1_inf       <= s0_inf_i;
      s1_snan      <= s0_snan_i;
      s1_qnan      <= s0_qnan_i;
      s1_anan_sign <= s0_anan_sign_i;
      s1_opc_0     <= s0_opc_0_i;
      s1_sign      <= s0_sign_i;
      s1_exp10c    <= s0_opc_0_i ? '0 : exp_sum;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2
  ////////////////////////////////////////////////////////////

  assign exp_zero = ~(|s1_exp10c);
  // 1025 - sum for a negative sum
  assign shr_neg  = ((EW+1)'(1) << EW) + (EW+1)'(1) - {1'b0, s1_exp10c};

  always_comb begin
    if (s1_opc_0) begin
      shr_full = '0;
      exp_rx   = '0;
    end else if (s1_exp10c[EW-1]) begin
      // negative sum, denormal result
      shr_full = shr_neg[EW-1:0];
      exp_rx   = EW'(1);
    end else begin
      // zero sum shifts once, normal sum not at all
      shr_full = {{(EW-1){1'b0}}, exp_zero};
      exp_rx   = s1_exp10c | {{(EW-1){1'b0}}, exp_zero};
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s2_inv_o       <= s1_inv;
      s2_inf_o       <= s1_inf;
      s2_snan_o      <= s1_snan;
      s2_qnan_o      <= s1_qnan;
      s2_anan_sign_o <= s1_anan_sign;
      s2_sign_o      <= s1_sign;
      s2_exp10c_o    <= s1_exp10c;
      // saturate to 31 when upper bits are set
      s2_shrx_o      <= shr_full[SW-1:0] | {SW{|shr_full[EW-1:SW]}};
      s2_exp10rx_o   <= exp_rx;
    end
  end

  // valid chain links 1 and 2
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_ready   <= 1'b0;
      s2_ready_o <= 1'b0;
    end else if (flush_i) begin
      s1_ready   <= 1'b0;
      s2_ready_o <= 1'b0;
    end else if (adv_i) begin
      s1_ready   <= s0_ready_i;
      s2_ready_o <= s1_ready;
    end
  end

endmodule

// File: rtl/fmul_prenorm.sv
////////////////////////////////////////////////////////////
// stage 0 of the multiplier: exception detection, leading
// zero counts and the registered operand set
////////////////////////////////////////////////////////////

module fmul_prenorm (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush_i,
  input  logic                            adv_i,
  input  logic                            start_i,
  // operand a
  input  logic                            signa_i,
  input  fp_format_pkg::exp_t             exp10a_i,
  input  fp_format_pkg::fract_t           fract24a_i,
  input  logic                            infa_i,
  input  logic                            zeroa_i,
  // operand b
  input  logic                            signb_i,
  input  fp_format_pkg::exp_t             exp10b_i,
  input  fp_format_pkg::fract_t           fract24b_i,
  input  logic                            infb_i,
  input  logic                            zerob_i,
  // nan info from upstream
  input  logic                            snan_i,
  input  logic                            qnan_i,
  input  logic                            anan_sign_i,
  // stage 0 registers
  output logic                            s0_ready_o,
  output logic                            s0_inv_o,
  output logic                            s0_inf_o,
  output logic                            s0_snan_o,
  output logic                            s0_qnan_o,
  output logic                            s0_anan_sign_o,
  output logic                            s0_opc_0_o,
  output logic                            s0_sign_o,
  output fp_format_pkg::exp_t             s0_exp10a_o,
  output fp_format_pkg::fract_t           s0_fract24a_o,
  output logic [fp_format_pkg::NLZ_W-1:0] s0_nlza_o,
  output fp_format_pkg::exp_t             s0_exp10b_o,
  output fp_format_pkg::fract_t           s0_fract24b_o,
  output logic [fp_format_pkg::NLZ_W-1:0] s0_nlzb_o
);

  logic [fp_format_pkg::NLZ_W-1:0] nlza;
  logic [fp_format_pkg::NLZ_W-1:0] nlzb;

  // 0 * inf in either order is invalid
  wire inv = (zeroa_i & infb_i) | (zerob_i & infa_i);
  // any infinite input gives an infinite product
  wire inf = infa_i | infb_i;
  // any zero input forces fraction and exponent to zero
  wire opc_0 = zeroa_i | zerob_i;

  lzc24 u_lzc_a (
    .fract_i (fract24a_i),
    .nlz_o   (nlza)
  );

  lzc24 u_lzc_b (
    .fract_i (fract24b_i),
    .nlz_o   (nlzb)
  );

  // operand and flag registers
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s0_inv_o       <= inv;
      s0_inf_o       <= inf;
      s0_snan_o      <= snan_i;
      s0_qnan_o      <= qnan_i;
      s0_anan_sign_o <= anan_sign_i;
      s0_opc_0_o     <= opc_0;
      s0_sign_o      <= signa_i ^ signb_i;
      s0_exp10a_o    <= exp10a_i;
      s0_fract24a_o  <= fract24a_i;
      s0_nlza_o      <= nlza;
      s0_exp10b_o    <= exp10b_i;
      s0_fract24b_o  <= fract24b_i;
      s0_nlzb_o      <= nlzb;
    end
  end

  // first link of the valid chain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s0_ready_o <= 1'b0;
    end else if (flush_i) begin
      s0_ready_o <= 1'b0;
    end else if (adv_i) begin
      s0_ready_o <= start_i;
    end
  end

endmodule

// File: rtl/lzc24.sv
////////////////////////////////////////////////////////////
// priority leading-zero counter for one 24-bit fraction
////////////////////////////////////////////////////////////

module lzc24 (
  input  fp_format_pkg::fract_t           fract_i,
  output logic [fp_format_pkg::NLZ_W-1:0] nlz_o
);

  localparam int FW = fp_format_pkg::FRACT_W;
  localparam int NW = fp_format_pkg::NLZ_W;

  // scan upwards so the highest set bit is the last one to win
  // all-zero fraction leaves the count at 0
  always_comb begin
    nlz_o = '0;
    for (int i = 0; i < FW; i++) begin
      if (fract_i[i]) begin
        nlz_o = NW'(FW - 1 - i);
      end
    end
  end

endmodule

// File: rtl/mul_pipe_pkg.sv
////////////////////////////////////////////////////////////
// widths of the split multiplier and the pipeline outputs
////////////////////////////////////////////////////////////

package mul_pipe_pkg;

  // one multiplier operand half
  localparam int HALF_W = 16;

  // multiplier operand, fraction followed by 8 zero bits
  localparam int MOP_W = 32;

  // kept product window
  localparam int PRODUCT_W = 48;

  // output fraction, 27 product bits plus sticky
  localparam int FRACT28_W = 28;

  // saturated right-shift amount
  localparam int SHR_W = 5;

  typedef logic [HALF_W-1:0] half_t;
  typedef logic [SHR_W-1:0]  shr_t;

endpackage

// File: rtl/fp_format_pkg.sv
////////////////////////////////////////////////////////////
// unpacked single-precision operand format for the multiply
// pipeline, referenced by scoped name from the RTL
////////////////////////////////////////////////////////////

package fp_format_pkg;

  // biased exponent, two bits wider than IEEE for under/overflow
  localparam int EXP_W = 10;

  // fraction including the hidden bit
  localparam int FRACT_W = 24;

  // leading-zero count of one fraction
  localparam int NLZ_W = 5;

  // single-precision bias, default of the core parameter
  localparam int EXP_BIAS = 127;

  typedef logic [EXP_W-1:0]   exp_t;
  typedef logic [FRACT_W-1:0] fract_t;

endpackage
